// ==== Makefile ====
VERILATOR ?= verilator
FLAGS     ?= --binary --timing --assert
TOP       ?= tb_mem_subsys
FILELIST  ?= files.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only --timing --assert --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)
	-./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1
	cat $(LOG)
	grep -q "TESTBENCH PASSED" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== axi_read_arbiter.sv ====
`timescale 1ns/100ps

module axi_read_arbiter #(
    parameter rv_mem_pkg::axi_id_t FETCH_ID = 4'd1
) (
    input  logic                clk,
    input  logic                rst_n,
    // fetch port
    input  logic                fetch_ar_valid,
    input  rv_mem_pkg::rd_req_t fetch_ar_req,
    output logic                fetch_ar_ready,
    output logic                fetch_r_valid,
    output rv_mem_pkg::rd_rsp_t fetch_r_rsp,
    input  logic                fetch_r_ready,
    // memory stage port
    input  logic                mem_ar_valid,
    input  rv_mem_pkg::rd_req_t mem_ar_req,
    output logic                mem_ar_ready,
    output logic                mem_r_valid,
    output rv_mem_pkg::rd_rsp_t mem_r_rsp,
    input  logic                mem_r_ready,
    // external channel
    output logic                ext_ar_valid,
    output rv_mem_pkg::rd_req_t ext_ar_req,
    input  logic                ext_ar_ready,
    input  logic                ext_r_valid,
    input  rv_mem_pkg::rd_rsp_t ext_r_rsp,
    output logic                ext_r_ready
);

    typedef enum logic {
        ARB_IDLE = 1'b0,
        ARB_BUSY = 1'b1
    } arb_state_t;

    arb_state_t state;

    logic last_fetch_q;
    // grant held while a presented request waits for ext_ar_ready
    logic pend_q;
    logic pend_fetch_q;
    logic sel_fetch;
    logic ar_hs;
    logic r_hs;
    logic rsp_fetch;
    logic rsp_mem;

    // round robin, the loser of the last tie goes first
    always_comb begin
        if (pend_q) begin
            sel_fetch = pend_fetch_q;
        end else if (fetch_ar_valid && mem_ar_valid) begin
            sel_fetch = !last_fetch_q;
        end else begin
            sel_fetch = fetch_ar_valid;
        end
    end

    assign ext_ar_valid   = (state == ARB_IDLE) && (sel_fetch ? fetch_ar_valid : mem_ar_valid);
    assign ext_ar_req     = sel_fetch ? fetch_ar_req : mem_ar_req;
    assign fetch_ar_ready = (state == ARB_IDLE) && sel_fetch && ext_ar_ready;
    assign mem_ar_ready   = (state == ARB_IDLE) && !sel_fetch && ext_ar_ready;
    assign ar_hs          = ext_ar_valid && ext_ar_ready;

    // response steering by id
    assign rsp_fetch     = (ext_r_rsp.id == FETCH_ID);
    assign rsp_mem       = (ext_r_rsp.id == rv_mem_pkg::MEM_ID);
    assign fetch_r_valid = (state == ARB_BUSY) && ext_r_valid && rsp_fetch;
    assign mem_r_valid   = (state == ARB_BUSY) && ext_r_valid && rsp_mem;
    assign fetch_r_rsp   = ext_r_rsp;
    assign mem_r_rsp     = ext_r_rsp;

    // unknown ids are sunk so the channel never hangs
    always_comb begin
        if (state != ARB_BUSY) begin
            ext_r_ready = 1'b0;
        end else if (rsp_fetch) begin
            ext_r_ready = fetch_r_ready;
        end else if (rsp_mem) begin
            ext_r_ready = mem_r_ready;
        end else begin
            ext_r_ready = 1'b1;
        end
    end

    assign r_hs = ext_r_valid && ext_r_ready;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state        <= ARB_IDLE;
            last_fetch_q <= 1'b1;
            pend_q       <= 1'b0;
            pend_fetch_q <= 1'b0;
        end else begin
            case (state)
                ARB_IDLE: begin
                    if (ar_hs) begin
                        state        <= ARB_BUSY;
                        last_fetch_q <= sel_fetch;
                        pend_q       <= 1'b0;
                    end else if (ext_ar_valid) begin
                        pend_q       <= 1'b1;
                        pend_fetch_q <= sel_fetch;
                    end
                end
                // one outstanding read, wait for its data beat
                ARB_BUSY: if (r_hs) state <= ARB_IDLE;
                default: state <= ARB_IDLE;
            endcase
        end
    end

endmodule

// ==== files.f ====
rv_mem_pkg.sv
load_extend.sv
mem_stage.sv
axi_read_arbiter.sv
mem_subsys_top.sv
mem_subsys_checker.sv
tb_axi_mem.sv
tb_mem_subsys.sv

// ==== load_extend.sv ====
`timescale 1ns/100ps

module load_extend (
    input  rv_mem_pkg::xlen_t    data,
    input  logic [2:0]           byte_off,
    input  rv_mem_pkg::load_op_t load_op,
    output rv_mem_pkg::xlen_t    result
);

    // doubleword with the addressed byte moved down to bit 0
    rv_mem_pkg::xlen_t shifted;

    assign shifted = data >> {byte_off, 3'b000};

    always_comb begin
        case (load_op)
            // signed loads
            rv_mem_pkg::LB: begin
                result = {{56{shifted[7]}}, shifted[7:0]};
            end
            rv_mem_pkg::LH: begin
                result = {{48{shifted[15]}}, shifted[15:0]};
            end
            rv_mem_pkg::LW: begin
                result = {{32{shifted[31]}}, shifted[31:0]};
            end
            // unsigned loads
            rv_mem_pkg::LBU: begin
                result = {56'd0, shifted[7:0]};
            end
            rv_mem_pkg::LHU: begin
                result = {48'd0, shifted[15:0]};
            end
            rv_mem_pkg::LWU: begin
                result = {32'd0, shifted[31:0]};
            end
            // ld and none keep the whole shifted word
            default: begin
                result = shifted;
            end
        endcase
    end

endmodule

// ==== mem_stage.sv ====
`timescale 1ns/100ps

module mem_stage (
    input  logic                 clk,
    input  logic                 rst_n,
    // execute side
    input  logic                 ex_valid,
    input  rv_mem_pkg::load_op_t load_op,
    input  rv_mem_pkg::xlen_t    base,
    input  rv_mem_pkg::xlen_t    offset,
    input  rv_mem_pkg::xlen_t    ex_result,
    // writeback side
    output logic                 mem_busy,
    output logic                 wb_valid,
    output rv_mem_pkg::xlen_t    wb_result,
    // read request
    output logic                 ar_valid,
    output rv_mem_pkg::rd_req_t  ar_req,
    input  logic                 ar_ready,
    // read response
    input  logic                 r_valid,
    input  rv_mem_pkg::rd_rsp_t  r_rsp,
    output logic                 r_ready
);

    typedef enum logic [1:0] {
        IDLE = 2'd0,
        REQ  = 2'd1,
        WAIT = 2'd2,
        DONE = 2'd3
    } state_t;

    state_t state, state_nxt;

    // latched load
    rv_mem_pkg::xlen_t    addr_q;
    rv_mem_pkg::load_op_t op_q;
    rv_mem_pkg::xlen_t    rdata_q;
    rv_mem_pkg::xlen_t    ext_data;

    logic accept;
    logic ar_hs;
    logic r_hs;

    assign accept = (state == IDLE) && ex_valid && (load_op != rv_mem_pkg::NONE);
    assign ar_hs  = ar_valid && ar_ready;
    assign r_hs   = r_valid && r_ready;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= IDLE;
        end else begin
            state <= state_nxt;
        end
    end

    always_comb begin
        state_nxt = state;
        case (state)
            IDLE: if (accept) state_nxt = REQ;
            // stays until the arbiter takes the request
            REQ:  if (ar_hs) state_nxt = WAIT;
            WAIT: if (r_hs) state_nxt = DONE;
            // single writeback cycle
            DONE: state_nxt = IDLE;
            default: state_nxt = IDLE;
        endcase
    end

    // address and op captured on acceptance
    always_ff @(posedge clk) begin
        if (accept) begin
            addr_q <= base + offset;
            op_q   <= load_op;
        end
        if (r_hs) begin
            rdata_q <= r_rsp.data;
        end
    end

    // doubleword aligned request, low bits kept as byte offset
    assign ar_valid    = (state == REQ);
    assign ar_req.addr = {addr_q[63:3], 3'b000};
    assign ar_req.id   = rv_mem_pkg::MEM_ID;
    assign r_ready     = (state == WAIT);

    assign mem_busy = (state == REQ) || (state == WAIT);
    assign wb_valid = (state == DONE);

    load_extend u_ext (
        .data     (rdata_q),
        .byte_off (addr_q[2:0]),
        .load_op  (op_q),
        .result   (ext_data)
    );

    // non-loads see ex_result straight through
    assign wb_result = (state == DONE) ? ext_data : ex_result;

endmodule

// ==== mem_subsys_checker.sv ====
`timescale 1ns/100ps

module mem_subsys_checker (
    input logic                clk,
    input logic                rst_n,
    input logic                mem_ar_valid,
    input rv_mem_pkg::rd_req_t mem_ar_req,
    input logic                mem_ar_ready,
    input logic                fetch_ar_valid,
    input rv_mem_pkg::rd_req_t fetch_ar_req,
    input logic                fetch_ar_ready,
    input logic                ext_ar_valid,
    input rv_mem_pkg::rd_req_t ext_ar_req,
    input logic                ext_ar_ready,
    input logic                ext_r_valid,
    input logic                ext_r_ready,
    input logic                wb_valid
);

    int   fail_count = 0;
    logic busy_q;

    // outstanding read on the external channel
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            busy_q <= 1'b0;
        end else if (ext_ar_valid && ext_ar_ready) begin
            busy_q <= 1'b1;
        end else if (ext_r_valid && ext_r_ready) begin
            busy_q <= 1'b0;
        end
    end

    // valid and payload held until ready
    a_mem_hold: assert property (@(posedge clk) disable iff (!rst_n)
        mem_ar_valid && !mem_ar_ready |=> mem_ar_valid && $stable(mem_ar_req))
        else begin $error("memory request dropped before handshake"); fail_count++; end
    a_fetch_hold: assert property (@(posedge clk) disable iff (!rst_n)
        fetch_ar_valid && !fetch_ar_ready |=> fetch_ar_valid && $stable(fetch_ar_req))
        else begin $error("fetch request dropped before handshake"); fail_count++; end
    a_ext_hold: assert property (@(posedge clk) disable iff (!rst_n)
        ext_ar_valid && !ext_ar_ready |=> ext_ar_valid && $stable(ext_ar_req))
        else begin $error("external request dropped before handshake"); fail_count++; end

    // one transaction in flight
    a_single: assert property (@(posedge clk) disable iff (!rst_n)
        ext_ar_valid && ext_ar_ready |-> !busy_q)
        else begin $error("second read issued before response"); fail_count++; end

    a_wb_pulse: assert property (@(posedge clk) disable iff (!rst_n)
        wb_valid |=> !wb_valid)
        else begin $error("writeback valid longer than one cycle"); fail_count++; end

endmodule

bind mem_subsys_top mem_subsys_checker u_chk (
    .clk            (clk),
    .rst_n          (rst_n),
    .mem_ar_valid   (mem_ar_valid),
    .mem_ar_req     (mem_ar_req),
    .mem_ar_ready   (mem_ar_ready),
    .fetch_ar_valid (fetch_ar_valid),
    .fetch_ar_req   (fetch_ar_req),
    .fetch_ar_ready (fetch_ar_ready),
    .ext_ar_valid   (ext_ar_valid),
    .ext_ar_req     (ext_ar_req),
    .ext_ar_ready   (ext_ar_ready),
    .ext_r_valid    (ext_r_valid),
    .ext_r_ready    (ext_r_ready),
    .wb_valid       (wb_valid)
);

// ==== mem_subsys_top.sv ====
`timescale 1ns/100ps

module mem_subsys_top #(
    parameter rv_mem_pkg::axi_id_t FETCH_ID = 4'd1
) (
    input  logic                 clk,
    input  logic                 rst_n,
    // execute side
    input  logic                 ex_valid,
    input  rv_mem_pkg::load_op_t load_op,
    input  rv_mem_pkg::xlen_t    base,
    input  rv_mem_pkg::xlen_t    offset,
    input  rv_mem_pkg::xlen_t    ex_result,
    // writeback side
    output logic                 mem_busy,
    output logic                 wb_valid,
    output rv_mem_pkg::xlen_t    wb_result,
    // fetch requester
    input  logic                 fetch_ar_valid,
    input  rv_mem_pkg::rd_req_t  fetch_ar_req,
    output logic                 fetch_ar_ready,
    output logic                 fetch_r_valid,
    output rv_mem_pkg::rd_rsp_t  fetch_r_rsp,
    input  logic                 fetch_r_ready,
    // external read channel
    output logic                 ext_ar_valid,
    output rv_mem_pkg::rd_req_t  ext_ar_req,
    input  logic                 ext_ar_ready,
    input  logic                 ext_r_valid,
    input  rv_mem_pkg::rd_rsp_t  ext_r_rsp,
    output logic                 ext_r_ready
);

    // memory stage to arbiter
    logic                mem_ar_valid;
    rv_mem_pkg::rd_req_t mem_ar_req;
    logic                mem_ar_ready;
    logic                mem_r_valid;
    rv_mem_pkg::rd_rsp_t mem_r_rsp;
    logic                mem_r_ready;

    mem_stage u_mem_stage (
        .clk       (clk),
        .rst_n     (rst_n),
        .ex_valid  (ex_valid),
        .load_op   (load_op),
        .base      (base),
        .offset    (offset),
        .ex_result (ex_result),
        .mem_busy  (mem_busy),
        .wb_valid  (wb_valid),
        .wb_result (wb_result),
        .ar_valid  (mem_ar_valid),
        .ar_req    (mem_ar_req),
        .ar_ready  (mem_ar_ready),
        .r_valid   (mem_r_valid),
        .r_rsp     (mem_r_rsp),
        .r_ready   (mem_r_ready)
    );

    axi_read_arbiter #(
        .FETCH_ID (FETCH_ID)
    ) u_arb (
        .clk            (clk),
        .rst_n          (rst_n),
        .fetch_ar_valid (fetch_ar_valid),
        .fetch_ar_req   (fetch_ar_req),
        .fetch_ar_ready (fetch_ar_ready),
        .fetch_r_valid  (fetch_r_valid),
        .fetch_r_rsp    (fetch_r_rsp),
        .fetch_r_ready  (fetch_r_ready),
        .mem_ar_valid   (mem_ar_valid),
        .mem_ar_req     (mem_ar_req),
        .mem_ar_ready   (mem_ar_ready),
        .mem_r_valid    (mem_r_valid),
        .mem_r_rsp      (mem_r_rsp),
        .mem_r_ready    (mem_r_ready),
        .ext_ar_valid   (ext_ar_valid),
        .ext_ar_req     (ext_ar_req),
        .ext_ar_ready   (ext_ar_ready),
        .ext_r_valid    (ext_r_valid),
        .ext_r_rsp      (ext_r_rsp),
        .ext_r_ready    (ext_r_ready)
    );

endmodule

// ==== rv_mem_pkg.sv ====
package rv_mem_pkg;

    // data and address word of the 64-bit core
    typedef logic [63:0] xlen_t;

    // read transaction id
    typedef logic [3:0] axi_id_t;

    // load kinds, NONE marks a non-load instruction
    typedef enum logic [2:0] {
        NONE = 3'd0,
        LB   = 3'd1,
        LH   = 3'd2,
        LW   = 3'd3,
        LD   = 3'd4,
        LBU  = 3'd5,
        LHU  = 3'd6,
        LWU  = 3'd7
    } load_op_t;

    // id carried by every memory-stage read
    localparam axi_id_t MEM_ID = 4'd2;

    // read address beat
    typedef struct packed {
        xlen_t   addr;
        axi_id_t id;
    } rd_req_t;

    // read data beat
    typedef struct packed {
        xlen_t   data;
        axi_id_t id;
    } rd_rsp_t;

endpackage

// ==== tb_axi_mem.sv ====
`timescale 1ns/100ps

module tb_axi_mem #(
    parameter rv_mem_pkg::xlen_t DATA_KEY = 64'h0
) (
    input  logic                clk,
    input  logic                rst_n,
    // random stall controls from the testbench
    input  logic                ar_hold,
    input  logic                r_hold,
    input  logic                ar_valid,
    input  rv_mem_pkg::rd_req_t ar_req,
    output logic                ar_ready,
    output logic                r_valid,
    output rv_mem_pkg::rd_rsp_t r_rsp,
    input  logic                r_ready
);

    logic                pending;
    rv_mem_pkg::rd_req_t req_q;

    // one read in flight at a time
    assign ar_ready = !pending && !ar_hold;

    // data depends only on the aligned address
    assign r_rsp.data = {req_q.addr[63:3], 3'b000} ^ DATA_KEY;
    assign r_rsp.id   = req_q.id;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pending <= 1'b0;
            r_valid <= 1'b0;
            req_q   <= '0;
        end else begin
            if (ar_valid && ar_ready) begin
                pending <= 1'b1;
                req_q   <= ar_req;
            end
            // response delay, valid held once raised
            if (pending && !r_valid && !r_hold) begin
                r_valid <= 1'b1;
            end
            if (r_valid && r_ready) begin
                r_valid <= 1'b0;
                pending <= 1'b0;
            end
        end
    end

endmodule

// ==== tb_mem_subsys.sv ====
`timescale 1ns/100ps

module tb_mem_subsys;

    localparam rv_mem_pkg::axi_id_t FETCH_ID = 4'd1;
    localparam rv_mem_pkg::xlen_t DATA_KEY = 64'h5a3c_96e1_0f7b_c248;
    localparam int MAX_LOADS = 200;
    localparam int WORST_CYCLES = 64;
    localparam int CLK_PERIOD = 40;

    logic clk;
    logic rst_n;
    // execute and writeback side
    logic ex_valid;
    rv_mem_pkg::load_op_t load_op;
    rv_mem_pkg::xlen_t base;
    rv_mem_pkg::xlen_t offset;
    rv_mem_pkg::xlen_t ex_result;
    logic mem_busy;
    logic wb_valid;
    rv_mem_pkg::xlen_t wb_result;
    // fetch port
    logic fetch_ar_valid;
    rv_mem_pkg::rd_req_t fetch_ar_req;
    logic fetch_ar_ready;
    logic fetch_r_valid;
    rv_mem_pkg::rd_rsp_t fetch_r_rsp;
    logic fetch_r_ready;
    // external channel to the memory model
    logic ext_ar_valid;
    rv_mem_pkg::rd_req_t ext_ar_req;
    logic ext_ar_ready;
    logic ext_r_valid;
    rv_mem_pkg::rd_rsp_t ext_r_rsp;
    logic ext_r_ready;
    logic ar_hold;
    logic r_hold;

    // stimulus controls
    logic [31:0] lfsr;
    logic stall_en;
    logic fetch_en;
    logic tie_req;
    int hold_cnt;
    rv_mem_pkg::xlen_t fetch_q[$];
    // byte address of the load in progress
    rv_mem_pkg::xlen_t load_addr = '0;
    int value_errors = 0;
    int other_errors = 0;

    // reference state for the grant order
    logic outstanding = 1'b0;
    logic locked = 1'b0;
    logic last_fetch = 1'b1;
    logic exp_fetch = 1'b0;

    mem_subsys_top #(.FETCH_ID(FETCH_ID)) dut0 (.*);

    tb_axi_mem #(.DATA_KEY(DATA_KEY)) u_mem (
        .clk      (clk),
        .rst_n    (rst_n),
        .ar_hold  (ar_hold),
        .r_hold   (r_hold),
        .ar_valid (ext_ar_valid),
        .ar_req   (ext_ar_req),
        .ar_ready (ext_ar_ready),
        .r_valid  (ext_r_valid),
        .r_rsp    (ext_r_rsp),
        .r_ready  (ext_r_ready)
    );

    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
    endfunction

    // one lfsr step per bit taken
    task automatic take_bits(input int n, output logic [63:0] v);
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr_next(lfsr);
            v = {v[62:0], lfsr[0]};
        end
    endtask

    // expected writeback from the memory data rule
    function automatic rv_mem_pkg::xlen_t expect_load(input rv_mem_pkg::load_op_t op,
                                                      input rv_mem_pkg::xlen_t addr);
        rv_mem_pkg::xlen_t d;
        rv_mem_pkg::xlen_t s;
        d = {addr[63:3], 3'b000} ^ DATA_KEY;
        s = d >> (8 * addr[2:0]);
        case (op)
            rv_mem_pkg::LB:  return 64'($signed(s[7:0]));
            rv_mem_pkg::LH:  return 64'($signed(s[15:0]));
            rv_mem_pkg::LW:  return 64'($signed(s[31:0]));
            rv_mem_pkg::LBU: return 64'(s[7:0]);
            rv_mem_pkg::LHU: return 64'(s[15:0]);
            rv_mem_pkg::LWU: return 64'(s[31:0]);
            default:         return s;
        endcase
    endfunction

    task automatic value_error(input string name, input rv_mem_pkg::xlen_t exp,
                               input rv_mem_pkg::xlen_t act);
        $display("** Error %s: expected %h, actual %h", name, exp, act);
        value_errors++;
    endtask

    task automatic plain_error(input string what);
        $display("error: %s at %0t", what, $time);
        other_errors++;
    endtask

    task automatic check_idle_outputs();
        assert (!wb_valid && !mem_busy && !ext_ar_valid && !fetch_ar_ready &&
                !fetch_r_valid && !ext_r_ready && !dut0.mem_ar_valid && !dut0.mem_r_ready)
            else plain_error("outputs not idle after reset");
    endtask

    // one load from acceptance to writeback, entered and left 1 ns after an edge
    task automatic run_load(input rv_mem_pkg::load_op_t op, input rv_mem_pkg::xlen_t b,
                            input rv_mem_pkg::xlen_t o);
        rv_mem_pkg::xlen_t addr;
        addr = b + o;
        load_addr = addr;
        ex_valid = 1'b1;
        load_op = op;
        base = b;
        offset = o;
        ex_result = ~b;
        do begin
            @(posedge clk);
            #1;
        end while (!mem_busy);
        ex_valid = 1'b0;
        while (!wb_valid) begin
            assert (mem_busy) else plain_error("mem_busy low while a load is pending");
            @(posedge clk);
            #1;
        end
        assert (wb_result == expect_load(op, addr))
            else value_error($sformatf("load op %0d offset %0d", op, addr[2:0]),
                             expect_load(op, addr), wb_result);
        @(posedge clk);
        #1;
        assert (!wb_valid) else plain_error("second writeback for one load");
    endtask

    task automatic run_nonload();
        logic [63:0] r;
        take_bits(64, r);
        ex_valid = 1'b1;
        load_op = rv_mem_pkg::NONE;
        ex_result = r;
        #1;
        assert (wb_result == r) else value_error("non-load passthrough", r, wb_result);
        assert (!wb_valid) else plain_error("writeback valid for a non-load");
        @(posedge clk);
        #1;
        assert (!mem_busy && !wb_valid) else plain_error("non-load started a memory access");
        ex_valid = 1'b0;
    endtask

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    // random stalls on the external channel
    always @(posedge clk) begin
        logic [63:0] r;
        #1;
        if (stall_en) begin
            take_bits(1, r);
            ar_hold = r[0];
            take_bits(1, r);
            r_hold = r[0];
        end
    end

    // fetch requester
    always @(posedge clk) begin
        logic fire;
        logic [63:0] r;
        fire = fetch_ar_valid && fetch_ar_ready;
        #1;
        if (fire) fetch_ar_valid = 1'b0;
        if (hold_cnt > 0) hold_cnt--;
        if (!fetch_ar_valid && rst_n) begin
            take_bits(1, r);
            if ((tie_req && dut0.mem_ar_valid) || (fetch_en && r[0])) begin
                take_bits(64, r);
                fetch_ar_req.addr = r;
                fetch_ar_req.id = FETCH_ID;
                fetch_ar_valid = 1'b1;
                fetch_q.push_back(r);
                tie_req = 1'b0;
            end
        end
        take_bits(1, r);
        fetch_r_ready = (hold_cnt == 0) && (!stall_en || r[0]);
    end

    // reference model of grant order and response routing
    always @(posedge clk) begin
        rv_mem_pkg::xlen_t a;
        rv_mem_pkg::xlen_t exp_addr;
        if (rst_n) begin
            if (!outstanding && ext_ar_valid && !locked) begin
                exp_fetch = (fetch_ar_valid && dut0.mem_ar_valid) ? !last_fetch : fetch_ar_valid;
                locked = 1'b1;
            end
            if (ext_ar_valid && ext_ar_ready) begin
                assert (ext_ar_req.id == (exp_fetch ? FETCH_ID : rv_mem_pkg::MEM_ID))
                    else value_error("grant id", 64'(exp_fetch ? FETCH_ID : rv_mem_pkg::MEM_ID),
                                     64'(ext_ar_req.id));
                // fetch address forwarded as is, load address doubleword aligned
                exp_addr = exp_fetch ? fetch_ar_req.addr : {load_addr[63:3], 3'b000};
                assert (ext_ar_req.addr == exp_addr)
                    else value_error("grant address", exp_addr, ext_ar_req.addr);
                last_fetch = exp_fetch;
                locked = 1'b0;
                outstanding = 1'b1;
            end
            if (ext_r_valid && ext_r_ready) outstanding = 1'b0;
            if (fetch_r_valid && fetch_r_ready) begin
                if (fetch_q.size() == 0) begin
                    plain_error("fetch response without a request");
                end else begin
                    a = fetch_q.pop_front();
                    assert (fetch_r_rsp.id == FETCH_ID)
                        else value_error("fetch id", 64'(FETCH_ID), 64'(fetch_r_rsp.id));
                    assert (fetch_r_rsp.data == ({a[63:3], 3'b000} ^ DATA_KEY))
                        else value_error("fetch data", {a[63:3], 3'b000} ^ DATA_KEY,
                                         fetch_r_rsp.data);
                end
            end
            if (fetch_r_valid && !fetch_r_ready) begin
                assert (!ext_r_ready && !dut0.mem_r_valid && !wb_valid)
                    else plain_error("memory stage moved past a stalled fetch response");
            end
            // the outstanding read must belong to the memory stage
            if (dut0.mem_r_valid) begin
                assert (!last_fetch)
                    else plain_error("load port received fetch data");
            end
        end
    end

    // watchdog sized from the worst-case load count
    initial begin
        #(MAX_LOADS * WORST_CYCLES * CLK_PERIOD);
        $display("watchdog expired, simulation stopped");
        $display("TESTBENCH FAILED");
        $finish;
    end

    initial begin
        logic [63:0] r;
        rst_n = 1'b0;
        ex_valid = 1'b0;
        load_op = rv_mem_pkg::NONE;
        base = '0;
        offset = '0;
        ex_result = '0;
        fetch_ar_valid = 1'b0;
        fetch_ar_req = '0;
        fetch_r_ready = 1'b1;
        ar_hold = 1'b1;
        r_hold = 1'b0;
        lfsr = 32'hd986d0d8;
        stall_en = 1'b0;
        fetch_en = 1'b0;
        tie_req = 1'b0;
        hold_cnt = 0;
        repeat (16) begin
            @(posedge clk);
            #1;
            check_idle_outputs();
        end
        rst_n = 1'b1;
        repeat (2) begin
            @(posedge clk);
            #1;
            check_idle_outputs();
        end
        stall_en = 1'b1;
        repeat (4) run_nonload();
        // every op at every byte offset
        for (int op = 1; op < 8; op++) begin
            for (int off = 0; off < 8; off++) begin
                take_bits(64, r);
                run_load(rv_mem_pkg::load_op_t'(op), {r[63:3], 3'b000}, 64'(off));
            end
        end
        // random loads against fetch traffic
        fetch_en = 1'b1;
        repeat (60) begin
            take_bits(3, r);
            load_op = (r[2:0] == 3'd0) ? rv_mem_pkg::LD : rv_mem_pkg::load_op_t'(r[2:0]);
            take_bits(64, r);
            base = r;
            take_bits(12, r);
            run_load(load_op, base, r);
        end
        fetch_en = 1'b0;
        while (fetch_ar_valid || fetch_q.size() != 0) begin
            @(posedge clk);
            #1;
        end
        // simultaneous requests with fetch back-pressure
        repeat (6) begin
            tie_req = 1'b1;
            hold_cnt = 12;
            take_bits(64, r);
            run_load(rv_mem_pkg::LD, r, 64'd0);
        end
        while (fetch_ar_valid || fetch_q.size() != 0) begin
            @(posedge clk);
            #1;
        end
        other_errors += dut0.u_chk.fail_count;
        $display("value errors: %0d, other errors: %0d", value_errors, other_errors);
        if (value_errors + other_errors == 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

endmodule
